/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= hl2_ctrl_tb
FILELIST  ?= files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* cmd_bus_if.sv */
interface cmd_bus_if import hl2_ctrl_pkg::*; ();

  // broadcast command bus, rqst qualifies the other three
  logic [CMD_ADDR_W-1:0] addr;
  logic [CMD_DATA_W-1:0] data;
  logic                  rqst;
  logic                  resprqst;

  modport source (
    output addr, data, rqst, resprqst
  );

  modport sink (
    input addr, data, rqst, resprqst
  );

endinterface

/* cmd_regs.sv */
module cmd_regs import hl2_ctrl_pkg::*; (
  input  logic              clk_ctrl,
  input  logic              reset_i,
  cmd_bus_if.sink           cmd,
  output logic              pa_enable_o,
  output logic              ext_tr_enable_o,
  output logic [HANG_W-1:0] tr_hang_ms_o
);

  cmd_op_e op;

  assign op = cmd_op_e'(cmd.addr);

  //////////////////////////////////////////////////
  // command slave

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      pa_enable_o     <= 1'b0;
      ext_tr_enable_o <= 1'b0;
      tr_hang_ms_o    <= '0;
    end else if (cmd.rqst) begin
      case (op)
        CMD_PA_CTRL: begin
          // bit 0 internal PA keying, bit 1 external T/R keying
          pa_enable_o     <= cmd.data[0];
          ext_tr_enable_o <= cmd.data[1];
        end
        CMD_TR_HANG: begin
          tr_hang_ms_o <= cmd.data[HANG_W-1:0];
        end
        default: begin
          // other addresses belong to other slaves
        end
      endcase
    end
  end

endmodule

/* files.f */
hl2_ctrl_pkg.sv
cmd_bus_if.sv
ms_timer.sv
cmd_regs.sv
tr_sequencer.sv
resp_builder.sv
hl2_ctrl_top.sv
hl2_ctrl_assertions.sv
hl2_ctrl_tb.sv

/* hl2_ctrl_assertions.sv */
module hl2_ctrl_assertions import hl2_ctrl_pkg::*; (
  input logic                  clk_ctrl,
  input logic                  reset_i,
  input logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input logic [CMD_DATA_W-1:0] cmd_data_i,
  input logic                  cmd_rqst_i,
  input logic                  cmd_resprqst_i,
  input logic                  tx_request_i,
  input logic                  tx_inhibit_i,
  input logic                  rxclip_i,
  input logic                  rffe_rfsw_sel_o,
  input logic                  pa_inttr_o,
  input logic                  pa_exttr_o,
  input logic                  tx_on_o,
  input logic [RESP_W-1:0]     resp_o,
  input logic                  resp_rqst_o,
  input logic                  qmsec_pulse_o,
  input logic                  msec_pulse_o
);

  int unsigned            fail_cnt = 0;
  logic                   pa_en_sh;
  logic                   ext_en_sh;
  logic [HANG_W-1:0]      hang_sh;
  logic [QMSEC_CNT_W-1:0] gap;
  logic                   seen_q;
  logic [QTR_CNT_W-1:0]   qcnt;
  logic                   tx_on_q;
  logic                   hang_wait;
  logic [HANG_W-1:0]      hang_cnt_q;
  logic [HANG_W-1:0]      hang_cur;
  logic                   fall_now;
  logic                   hang_end_now;
  logic                   clip_sh;
  logic [RESP_W-1:0]      resp_exp;

  // end of transmit with no pending request starts a hang window
  assign fall_now     = tx_on_q && !tx_on_o && !tx_request_i;
  assign hang_cur     = fall_now ? '0 : hang_cnt_q;
  // zero hang ends at once and any other value on its last msec pulse
  assign hang_end_now = (fall_now || hang_wait) &&
                        ((hang_sh == '0) ||
                         (msec_pulse_o && (HANG_W'(hang_cur + 1'b1) == hang_sh)));

  //////////////////////////////////////////////////
  // shadow state from the top ports

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      pa_en_sh   <= 1'b0;
      ext_en_sh  <= 1'b0;
      hang_sh    <= '0;
      gap        <= '0;
      seen_q     <= 1'b0;
      qcnt       <= '0;
      tx_on_q    <= 1'b0;
      hang_wait  <= 1'b0;
      hang_cnt_q <= '0;
      clip_sh    <= 1'b0;
      resp_exp   <= '0;
    end else begin
      if (cmd_rqst_i && (cmd_addr_i == CMD_PA_CTRL)) begin
        pa_en_sh  <= cmd_data_i[0];
        ext_en_sh <= cmd_data_i[1];
      end
      if (cmd_rqst_i && (cmd_addr_i == CMD_TR_HANG)) hang_sh <= cmd_data_i[HANG_W-1:0];
      gap        <= qmsec_pulse_o ? '0 : gap + 1'b1;
      seen_q     <= seen_q || qmsec_pulse_o;
      if (qmsec_pulse_o) qcnt <= qcnt + 1'b1;
      tx_on_q    <= tx_on_o;
      hang_wait  <= (fall_now || hang_wait) && !hang_end_now;
      hang_cnt_q <= hang_cur + HANG_W'(msec_pulse_o);
      // clip stays set until a response has carried it
      if (rxclip_i) clip_sh <= 1'b1;
      else if (resp_rqst_o) clip_sh <= 1'b0;
      if (cmd_rqst_i && cmd_resprqst_i)
        resp_exp <= {cmd_addr_i, tx_on_o, clip_sh, cmd_data_i};
    end
  end

  //////////////////////////////////////////////////
  // timer

  a_qmsec_width: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    qmsec_pulse_o |=> !qmsec_pulse_o)
    else begin
      fail_cnt++;
      $error("Error t=%0t qmsec_pulse_o wider than one cycle", $time);
    end

  a_qmsec_period: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    seen_q |-> (qmsec_pulse_o == (gap == QMSEC_CNT_W'(QMSEC_TICKS - 1))))
    else begin
      fail_cnt++;
      $error("Error t=%0t qmsec_pulse_o got %b expected %b", $time, qmsec_pulse_o,
             gap == QMSEC_CNT_W'(QMSEC_TICKS - 1));
    end

  a_msec: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    msec_pulse_o == (qmsec_pulse_o && (qcnt == QTR_CNT_W'(QMSEC_PER_MSEC - 1))))
    else begin
      fail_cnt++;
      $error("Error t=%0t msec_pulse_o got %b expected %b", $time, msec_pulse_o,
             qmsec_pulse_o && (qcnt == QTR_CNT_W'(QMSEC_PER_MSEC - 1)));
    end

  //////////////////////////////////////////////////
  // sequencer

  a_tx_rise: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    $rose(tx_on_o) |-> ($past(qmsec_pulse_o) && $past(rffe_rfsw_sel_o)))
    else begin
      fail_cnt++;
      $error("Error t=%0t tx_on_o rose outside a qmsec slot", $time);
    end

  a_tx_relay: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    tx_on_o |-> rffe_rfsw_sel_o)
    else begin
      fail_cnt++;
      $error("Error t=%0t tx_on_o high with relay in rx", $time);
    end

  a_pa_int: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    pa_inttr_o == (rffe_rfsw_sel_o && $past(pa_en_sh)))
    else begin
      fail_cnt++;
      $error("Error t=%0t pa_inttr_o got %b expected %b", $time, pa_inttr_o,
             rffe_rfsw_sel_o && $past(pa_en_sh));
    end

  a_pa_ext: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    pa_exttr_o == (rffe_rfsw_sel_o && $past(ext_en_sh)))
    else begin
      fail_cnt++;
      $error("Error t=%0t pa_exttr_o got %b expected %b", $time, pa_exttr_o,
             rffe_rfsw_sel_o && $past(ext_en_sh));
    end

  a_inhibit: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    tx_inhibit_i |=> !tx_on_o)
    else begin
      fail_cnt++;
      $error("Error t=%0t tx_on_o got 1 expected 0", $time);
    end

  a_hang_hold: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    ((fall_now || hang_wait) && !hang_end_now) |=> rffe_rfsw_sel_o)
    else begin
      fail_cnt++;
      $error("Error t=%0t rffe_rfsw_sel_o got 0 expected 1", $time);
    end

  a_hang_end: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    hang_end_now |=> !rffe_rfsw_sel_o)
    else begin
      fail_cnt++;
      $error("Error t=%0t rffe_rfsw_sel_o got 1 expected 0", $time);
    end

  //////////////////////////////////////////////////
  // response

  a_resp_strobe: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    resp_rqst_o == $past(cmd_rqst_i && cmd_resprqst_i))
    else begin
      fail_cnt++;
      $error("Error t=%0t resp_rqst_o got %b expected %b", $time, resp_rqst_o,
             $past(cmd_rqst_i && cmd_resprqst_i));
    end

  a_resp_word: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    resp_rqst_o |-> (resp_o == resp_exp))
    else begin
      fail_cnt++;
      $error("Error t=%0t resp_o got %h expected %h", $time, resp_o, resp_exp);
    end

endmodule

bind hl2_ctrl_top hl2_ctrl_assertions chk (.*);

/* hl2_ctrl_pkg.sv */
package hl2_ctrl_pkg;

  //////////////////////////////////////////////////
  // bus and register widths

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;
  localparam int RESP_W     = 40;
  localparam int HANG_W     = 8;

  //////////////////////////////////////////////////
  // time base, clk_ctrl runs at 2.5 MHz

  localparam int QMSEC_TICKS    = 625;
  localparam int QMSEC_PER_MSEC = 4;
  localparam int QMSEC_CNT_W    = $clog2(QMSEC_TICKS);
  localparam int QTR_CNT_W      = $clog2(QMSEC_PER_MSEC);

  // command addresses decoded on the clk_ctrl side
  typedef enum logic [CMD_ADDR_W-1:0] {
    CMD_PA_CTRL = 6'h09,
    CMD_TR_HANG = 6'h17
  } cmd_op_e;

  // T/R sequencer states
  typedef enum logic [1:0] {
    TR_RX,
    TR_SWITCH,
    TR_TX,
    TR_HANG
  } tr_state_e;

endpackage

/* hl2_ctrl_tb.sv */
module hl2_ctrl_tb import hl2_ctrl_pkg::*; ();

  // worst case over all bursts is about 48000 cycles
  localparam int CYCLE_LIMIT = 60000;

  logic                  clk_ctrl;
  logic                  reset_i;
  logic [CMD_ADDR_W-1:0] cmd_addr_i;
  logic [CMD_DATA_W-1:0] cmd_data_i;
  logic                  cmd_rqst_i;
  logic                  cmd_resprqst_i;
  logic                  tx_request_i;
  logic                  tx_inhibit_i;
  logic                  rxclip_i;
  logic                  rffe_rfsw_sel_o;
  logic                  pa_inttr_o;
  logic                  pa_exttr_o;
  logic                  tx_on_o;
  logic [RESP_W-1:0]     resp_o;
  logic                  resp_rqst_o;
  logic                  qmsec_pulse_o;
  logic                  msec_pulse_o;
  logic [31:0]           rng_state = 32'h58fd_2d37;
  int                    cycle_cnt = 0;
  bit                    run_passed = 0;
  bit                    fail_printed = 0;

  hl2_ctrl_top uut (.*);

  initial begin
    clk_ctrl = 1'b0;
    forever #50 clk_ctrl = ~clk_ctrl;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Verification failed");
    fail_printed = 1;
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // watchdog and checker monitor

  always @(posedge clk_ctrl) begin
    cycle_cnt++;
    if (uut.chk.fail_cnt != 0) report_failure("an assertion in the checker failed");
    else if (cycle_cnt >= CYCLE_LIMIT) report_failure("timeout, the run took too many cycles");
  end

  final begin
    if (!run_passed && !fail_printed) $display("Verification failed");
  end

  task automatic write_cmd(input logic [CMD_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic resp);
    @(posedge clk_ctrl);
    cmd_addr_i     <= addr;
    cmd_data_i     <= data;
    cmd_rqst_i     <= 1'b1;
    cmd_resprqst_i <= resp;
    @(posedge clk_ctrl);
    cmd_rqst_i     <= 1'b0;
    cmd_resprqst_i <= 1'b0;
  endtask

  // random command traffic and clip pulses while transmitting
  task automatic random_traffic(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_ctrl);
      r = next_rand();
      rxclip_i       <= (r[3:0] == 4'h0);
      cmd_rqst_i     <= (r[7:5] == 3'h0);
      cmd_addr_i     <= (r[13:8] == CMD_TR_HANG) ? 6'h3a : r[13:8];
      cmd_resprqst_i <= r[14];
      cmd_data_i     <= next_rand();
    end
    @(posedge clk_ctrl);
    rxclip_i       <= 1'b0;
    cmd_rqst_i     <= 1'b0;
    cmd_resprqst_i <= 1'b0;
  endtask

  task automatic tx_burst(input logic [HANG_W-1:0] hang, input int hold);
    logic [31:0] pa_data;
    logic [31:0] r;
    pa_data = next_rand();
    r       = next_rand();
    write_cmd(CMD_TR_HANG, 32'(hang), 1'b1);
    write_cmd(CMD_PA_CTRL, pa_data, r[0]);
    @(posedge clk_ctrl);
    tx_request_i <= 1'b1;
    while (!tx_on_o) @(posedge clk_ctrl);
    random_traffic(hold);
    tx_request_i <= 1'b0;
    while (rffe_rfsw_sel_o) @(posedge clk_ctrl);
  endtask

  initial begin
    logic [31:0] hang_pick;
    logic [31:0] hold_pick;
    reset_i        = 1'b1;
    cmd_addr_i     = '0;
    cmd_data_i     = '0;
    cmd_rqst_i     = 1'b0;
    cmd_resprqst_i = 1'b0;
    tx_request_i   = 1'b0;
    tx_inhibit_i   = 1'b0;
    rxclip_i       = 1'b0;
    repeat (4) @(posedge clk_ctrl);
    reset_i <= 1'b0;
    for (int i = 0; i < 5; i++) begin
      hang_pick = next_rand();
      hold_pick = next_rand();
      tx_burst(HANG_W'(hang_pick[1:0]), 100 + hold_pick[6:0]);
    end
    tx_burst('0, 50);
    // inhibit while the relay is switching
    @(posedge clk_ctrl);
    tx_request_i <= 1'b1;
    @(posedge clk_ctrl);
    tx_inhibit_i <= 1'b1;
    repeat (700) @(posedge clk_ctrl);
    tx_request_i <= 1'b0;
    tx_inhibit_i <= 1'b0;
    while (rffe_rfsw_sel_o) @(posedge clk_ctrl);
    // inhibit during transmit
    @(posedge clk_ctrl);
    tx_request_i <= 1'b1;
    while (!tx_on_o) @(posedge clk_ctrl);
    repeat (10 + (next_rand() & 31)) @(posedge clk_ctrl);
    tx_inhibit_i <= 1'b1;
    repeat (20 + (next_rand() & 31)) @(posedge clk_ctrl);
    tx_request_i <= 1'b0;
    tx_inhibit_i <= 1'b0;
    while (rffe_rfsw_sel_o) @(posedge clk_ctrl);
    random_traffic(300);
    repeat (3000) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    if (uut.chk.fail_cnt == 0) begin
      run_passed = 1;
      $display("Verification passed");
      $finish;
    end else begin
      report_failure("the checker counted failed assertions");
    end
  end

endmodule

/* hl2_ctrl_top.sv */
module hl2_ctrl_top import hl2_ctrl_pkg::*; (
  input  logic                  clk_ctrl,
  input  logic                  reset_i,
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [CMD_DATA_W-1:0] cmd_data_i,
  input  logic                  cmd_rqst_i,
  input  logic                  cmd_resprqst_i,
  input  logic                  tx_request_i,
  input  logic                  tx_inhibit_i,
  input  logic                  rxclip_i,
  output logic                  rffe_rfsw_sel_o,
  output logic                  pa_inttr_o,
  output logic                  pa_exttr_o,
  output logic                  tx_on_o,
  output logic [RESP_W-1:0]     resp_o,
  output logic                  resp_rqst_o,
  output logic                  qmsec_pulse_o,
  output logic                  msec_pulse_o
);

  logic              pa_enable;
  logic              ext_tr_enable;
  logic [HANG_W-1:0] tr_hang_ms;

  //////////////////////////////////////////////////
  // command bus

  cmd_bus_if cmd_bus ();

  assign cmd_bus.addr     = cmd_addr_i;
  assign cmd_bus.data     = cmd_data_i;
  assign cmd_bus.rqst     = cmd_rqst_i;
  assign cmd_bus.resprqst = cmd_resprqst_i;

  //////////////////////////////////////////////////
  // clk_ctrl blocks

  ms_timer ms_timer_i (
    .clk_ctrl      (clk_ctrl),
    .reset_i       (reset_i),
    .qmsec_pulse_o (qmsec_pulse_o),
    .msec_pulse_o  (msec_pulse_o)
  );

  cmd_regs cmd_regs_i (
    .clk_ctrl        (clk_ctrl),
    .reset_i         (reset_i),
    .cmd             (cmd_bus),
    .pa_enable_o     (pa_enable),
    .ext_tr_enable_o (ext_tr_enable),
    .tr_hang_ms_o    (tr_hang_ms)
  );

  tr_sequencer tr_sequencer_i (
    .clk_ctrl        (clk_ctrl),
    .reset_i         (reset_i),
    .tx_request_i    (tx_request_i),
    .tx_inhibit_i    (tx_inhibit_i),
    .qmsec_pulse_i   (qmsec_pulse_o),
    .msec_pulse_i    (msec_pulse_o),
    .pa_enable_i     (pa_enable),
    .ext_tr_enable_i (ext_tr_enable),
    .tr_hang_ms_i    (tr_hang_ms),
    .rffe_rfsw_sel_o (rffe_rfsw_sel_o),
    .pa_inttr_o      (pa_inttr_o),
    .pa_exttr_o      (pa_exttr_o),
    .tx_on_o         (tx_on_o)
  );

  // tx state in the response comes straight from the sequencer
  resp_builder resp_builder_i (
    .clk_ctrl    (clk_ctrl),
    .reset_i     (reset_i),
    .cmd         (cmd_bus),
    .tx_on_i     (tx_on_o),
    .rxclip_i    (rxclip_i),
    .resp_o      (resp_o),
    .resp_rqst_o (resp_rqst_o)
  );

endmodule

/* ms_timer.sv */
module ms_timer import hl2_ctrl_pkg::*; (
  input  logic clk_ctrl,
  input  logic reset_i,
  output logic qmsec_pulse_o,
  output logic msec_pulse_o
);

  logic [QMSEC_CNT_W-1:0] tick_cnt;
  logic [QTR_CNT_W-1:0]   qtr_cnt;
  logic                   tick_wrap;

  // last tick of a quarter millisecond
  assign tick_wrap = (tick_cnt == QMSEC_CNT_W'(QMSEC_TICKS - 1));

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      tick_cnt      <= '0;
      qtr_cnt       <= '0;
      qmsec_pulse_o <= 1'b0;
      msec_pulse_o  <= 1'b0;
    end else begin
      qmsec_pulse_o <= tick_wrap;
      // every fourth quarter pulse also marks a full millisecond
      msec_pulse_o  <= tick_wrap && (qtr_cnt == QTR_CNT_W'(QMSEC_PER_MSEC - 1));
      if (tick_wrap) begin
        tick_cnt <= '0;
        qtr_cnt  <= qtr_cnt + 1'b1;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

endmodule

/* resp_builder.sv */
module resp_builder import hl2_ctrl_pkg::*; (
  input  logic              clk_ctrl,
  input  logic              reset_i,
  cmd_bus_if.sink           cmd,
  input  logic              tx_on_i,
  input  logic              rxclip_i,
  output logic [RESP_W-1:0] resp_o,
  output logic              resp_rqst_o
);

  logic clip_q;
  logic resp_take;

  assign resp_take = cmd.rqst && cmd.resprqst;

  //////////////////////////////////////////////////
  // adc clip latch

  // held until reported, a clip during the report keeps it set
  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      clip_q <= 1'b0;
    end else begin
      clip_q <= rxclip_i || (clip_q && !resp_rqst_o);
    end
  end

  //////////////////////////////////////////////////
  // response word and strobe

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      resp_o      <= '0;
      resp_rqst_o <= 1'b0;
    end else begin
      resp_rqst_o <= resp_take;
      if (resp_take) begin
        // addr, tx state, clip, echoed data
        resp_o <= {cmd.addr, tx_on_i, clip_q, cmd.data};
      end
    end
  end

endmodule

/* tr_sequencer.sv */
module tr_sequencer import hl2_ctrl_pkg::*; (
  input  logic              clk_ctrl,
  input  logic              reset_i,
  input  logic              tx_request_i,
  input  logic              tx_inhibit_i,
  input  logic              qmsec_pulse_i,
  input  logic              msec_pulse_i,
  input  logic              pa_enable_i,
  input  logic              ext_tr_enable_i,
  input  logic [HANG_W-1:0] tr_hang_ms_i,
  output logic              rffe_rfsw_sel_o,
  output logic              pa_inttr_o,
  output logic              pa_exttr_o,
  output logic              tx_on_o
);

  tr_state_e         state_q;
  tr_state_e         state_d;
  logic [HANG_W-1:0] hang_cnt;
  logic              tx_go;
  logic              hang_done;

  // transmit allowed this cycle
  assign tx_go = tx_request_i && !tx_inhibit_i;

  // hang is over once the msec count reaches the programmed value,
  // a pulse in this cycle already counts
  assign hang_done = (hang_cnt == tr_hang_ms_i) ||
                     (msec_pulse_i && (HANG_W'(hang_cnt + 1'b1) == tr_hang_ms_i));

  //////////////////////////////////////////////////
  // next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      TR_RX: begin
        if (tx_go) state_d = TR_SWITCH;
      end
      TR_SWITCH: begin
        // relay settles until the next quarter ms boundary
        if (tx_inhibit_i) state_d = TR_RX;
        else if (qmsec_pulse_i) state_d = TR_TX;
      end
      TR_TX: begin
        if (!tx_go) state_d = TR_HANG;
      end
      TR_HANG: begin
        if (tx_go) state_d = TR_TX;
        else if (hang_done) state_d = TR_RX;
      end
      default: state_d = TR_RX;
    endcase
  end

  //////////////////////////////////////////////////
  // state, hang counter and registered outputs

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      state_q         <= TR_RX;
      hang_cnt        <= '0;
      rffe_rfsw_sel_o <= 1'b0;
      pa_inttr_o      <= 1'b0;
      pa_exttr_o      <= 1'b0;
      tx_on_o         <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q != TR_HANG) hang_cnt <= '0;
      else if (msec_pulse_i) hang_cnt <= hang_cnt + 1'b1;
      // relay stays switched for the whole tx and hang window
      rffe_rfsw_sel_o <= (state_d != TR_RX);
      pa_inttr_o      <= (state_d != TR_RX) && pa_enable_i;
      pa_exttr_o      <= (state_d != TR_RX) && ext_tr_enable_i;
      tx_on_o         <= (state_d == TR_TX);
    end
  end

endmodule
